// File: logic/display_pkg.sv
package display_pkg;

  //////////////////////////////
  // Display geometry
  //////////////////////////////

  localparam int DIGIT_COUNT = 8;   // Digits on the display
  localparam int VALUE_WIDTH = 24;  // Signed input value
  localparam int LED_WIDTH   = 16;  // LED bank

  //////////////////////////////
  // Digit and frame types
  //////////////////////////////

  // One decimal digit code, 0 to 9, or the minus sign
  typedef logic [3:0] digit_t;

  localparam digit_t MINUS_DIGIT = 4'hF;

  // Converted value as handed to the scan driver
  // Digit 7 is the leftmost position
  typedef struct packed {
    logic                          negative;
    digit_t [DIGIT_COUNT-1:0]      digits;
  } digit_frame_t;

  //////////////////////////////
  // Converter FSM
  //////////////////////////////

  typedef enum logic [1:0] {
    IDLE,   // Waiting for a queued value
    LOAD,   // Sign and magnitude
    SHIFT,  // Shift-add-3 steps
    WRITE   // Frame out, credit back
  } conv_state_t;

endpackage

// File: logic/bcd_converter.sv
`timescale 1ns/10ps

module bcd_converter #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      value_valid,
  input  logic signed [display_pkg::VALUE_WIDTH-1:0] value,
  output logic                                      credit_return,
  output logic                                      frame_valid,
  output display_pkg::digit_frame_t                 frame
);
  import display_pkg::*;

  localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
  localparam int BCD_W  = 4 * DIGIT_COUNT;
  localparam int STEP_W = $clog2(VALUE_WIDTH);

  // Input queue
  logic signed [VALUE_WIDTH-1:0] queue_mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]              wr_ptr;
  logic [PTR_W-1:0]              rd_ptr;
  logic [CNT_W-1:0]              count;
  logic                          pop;

  // Conversion datapath
  conv_state_t                   state;
  logic signed [VALUE_WIDTH-1:0] held;
  logic                          negative;
  logic [VALUE_WIDTH-1:0]        bin_shift;
  logic [BCD_W-1:0]              bcd_shift;
  logic [BCD_W-1:0]              bcd_adjusted;
  logic [STEP_W-1:0]             step;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////
  // Circular input queue
  //////////////////////////////

  assign pop = (state == IDLE) && (count != '0);

  always_ff @(posedge clk) begin
    if (value_valid) queue_mem[wr_ptr] <= value;  // Sender holds a credit
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (value_valid) wr_ptr <= next_ptr(wr_ptr);
      if (pop) rd_ptr <= next_ptr(rd_ptr);
      case ({value_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  //////////////////////////////
  // Shift-add-3 conversion
  //////////////////////////////

  // Any nibble of 5 or more gets 3 added before the shift
  always_comb begin
    for (int i = 0; i < DIGIT_COUNT; i++) begin
      if (bcd_shift[4*i +: 4] >= 4'd5) begin
        bcd_adjusted[4*i +: 4] = bcd_shift[4*i +: 4] + 4'd3;
      end else begin
        bcd_adjusted[4*i +: 4] = bcd_shift[4*i +: 4];
      end
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      IDLE: if (pop) held <= queue_mem[rd_ptr];
      LOAD: begin
        negative  <= held[VALUE_WIDTH-1];
        bin_shift <= held[VALUE_WIDTH-1] ? VALUE_WIDTH'(~held + 1'b1) : held;
        bcd_shift <= '0;
      end
      SHIFT: {bcd_shift, bin_shift} <= {bcd_adjusted, bin_shift} << 1;
      default: ;
    endcase
  end

  // Pop, load, 24 steps, write: 27 cycles to frame_valid
  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= IDLE;
      step          <= '0;
      frame         <= '0;
      frame_valid   <= 1'b0;
      credit_return <= 1'b0;
    end else begin
      frame_valid   <= 1'b0;
      credit_return <= 1'b0;
      case (state)
        IDLE: if (pop) state <= LOAD;
        LOAD: begin
          step  <= '0;
          state <= SHIFT;
        end
        SHIFT: begin
          step <= step + 1'b1;
          if (step == STEP_W'(VALUE_WIDTH - 1)) state <= WRITE;
        end
        WRITE: begin
          frame.negative <= negative;
          for (int i = 0; i < DIGIT_COUNT; i++) begin
            frame.digits[i] <= digit_t'(bcd_shift[4*i +: 4]);
          end
          if (negative) frame.digits[DIGIT_COUNT-1] <= MINUS_DIGIT;  // Leftmost shows minus
          frame_valid   <= 1'b1;
          credit_return <= 1'b1;  // Slot freed
          state         <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: logic/tick_generator.sv
`timescale 1ns/10ps

module tick_generator #(
  parameter int SCAN_DIV  = 100000,
  parameter int BLINK_DIV = 333
) (
  input  logic clk,
  input  logic rst,
  output logic scan_tick,
  output logic blink_phase
);

  localparam int SCAN_W  = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
  localparam int BLINK_W = (BLINK_DIV > 1) ? $clog2(BLINK_DIV) : 1;

  logic [SCAN_W-1:0]  scan_cnt;
  logic [BLINK_W-1:0] blink_cnt;
  logic               scan_wrap;

  assign scan_wrap = (scan_cnt == SCAN_W'(SCAN_DIV - 1));

  // One-cycle tick every SCAN_DIV clocks
  always_ff @(posedge clk) begin
    if (rst) begin
      scan_cnt  <= '0;
      scan_tick <= 1'b0;
    end else begin
      scan_tick <= scan_wrap;
      scan_cnt  <= scan_wrap ? '0 : scan_cnt + 1'b1;
    end
  end

  // Blink phase flips every BLINK_DIV ticks
  always_ff @(posedge clk) begin
    if (rst) begin
      blink_cnt   <= '0;
      blink_phase <= 1'b1;  // Start in the on half
    end else if (scan_tick) begin
      if (blink_cnt == BLINK_W'(BLINK_DIV - 1)) begin
        blink_cnt   <= '0;
        blink_phase <= ~blink_phase;
      end else begin
        blink_cnt <= blink_cnt + 1'b1;
      end
    end
  end

endmodule

// File: logic/scan_driver.sv
`timescale 1ns/10ps

module scan_driver (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               frame_valid,
  input  display_pkg::digit_frame_t          frame,
  input  logic                               scan_tick,
  input  logic                               blink_phase,
  input  logic                               blink,
  input  logic [display_pkg::LED_WIDTH-1:0]  led_in,
  output logic [display_pkg::DIGIT_COUNT-1:0] seg_en,
  output logic [7:0]                         seg,
  output logic [display_pkg::LED_WIDTH-1:0]  led_out
);
  import display_pkg::*;

  localparam int IDX_W = $clog2(DIGIT_COUNT);

  digit_frame_t           shown_frame;
  logic [IDX_W-1:0]       digit_idx;    // Digit lit on the next tick
  logic [DIGIT_COUNT-1:0] active_en;
  logic [DIGIT_COUNT-1:0] next_en;
  logic [7:0]             seg_pattern;
  logic                   blank;

  // Active-low segments, bit 0 is a, bit 7 is the dot
  function automatic logic [7:0] encode_digit(input digit_t digit);
    case (digit)
      4'd0:    return 8'hC0;
      4'd1:    return 8'hF9;
      4'd2:    return 8'hA4;
      4'd3:    return 8'hB0;
      4'd4:    return 8'h99;
      4'd5:    return 8'h92;
      4'd6:    return 8'h82;
      4'd7:    return 8'hF8;
      4'd8:    return 8'h80;
      4'd9:    return 8'h90;
      4'hF:    return 8'hBF;  // Minus, segment g only
      default: return 8'hFF;
    endcase
  endfunction

  assign blank       = blink && !blink_phase;  // Off half of the blink
  assign seg_pattern = encode_digit(shown_frame.digits[digit_idx]);
  assign next_en     = scan_tick ? ~(DIGIT_COUNT'(1) << digit_idx) : active_en;

  //////////////////////////////
  // Frame hold
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      shown_frame <= '0;
    end else if (frame_valid) begin
      shown_frame <= frame;
    end
  end

  //////////////////////////////
  // Digit scan
  //////////////////////////////

  // Leftmost first, 7 down to 0, then wrap
  always_ff @(posedge clk) begin
    if (rst) begin
      digit_idx <= IDX_W'(DIGIT_COUNT - 1);
      active_en <= '1;
      seg       <= '1;
    end else begin
      active_en <= next_en;
      if (scan_tick) begin
        seg       <= seg_pattern;
        digit_idx <= (digit_idx == '0) ? IDX_W'(DIGIT_COUNT - 1) : digit_idx - 1'b1;
      end
    end
  end

  // Enables registered with blanking applied
  always_ff @(posedge clk) begin
    if (rst) begin
      seg_en  <= '1;
      led_out <= '0;
    end else begin
      seg_en  <= blank ? '1 : next_en;
      led_out <= led_in;  // LEDs pass through one stage
    end
  end

endmodule

// File: logic/display_top.sv
`timescale 1ns/10ps

module display_top #(
  parameter int QUEUE_DEPTH = 2,
  parameter int SCAN_DIV    = 100000,
  parameter int BLINK_DIV   = 333
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       value_valid,
  input  logic signed [display_pkg::VALUE_WIDTH-1:0] value,
  output logic                                       credit_return,
  input  logic [display_pkg::LED_WIDTH-1:0]          led_in,
  input  logic                                       blink,
  output logic [display_pkg::DIGIT_COUNT-1:0]        seg_en,
  output logic [7:0]                                 seg,
  output logic [display_pkg::LED_WIDTH-1:0]          led_out
);
  import display_pkg::*;

  digit_frame_t frame;
  logic         frame_valid;
  logic         scan_tick;
  logic         blink_phase;

  bcd_converter #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_converter (
    .clk           (clk),
    .rst           (rst),
    .value_valid   (value_valid),
    .value         (value),
    .credit_return (credit_return),
    .frame_valid   (frame_valid),
    .frame         (frame)
  );

  tick_generator #(
    .SCAN_DIV  (SCAN_DIV),
    .BLINK_DIV (BLINK_DIV)
  ) u_ticks (
    .clk         (clk),
    .rst         (rst),
    .scan_tick   (scan_tick),
    .blink_phase (blink_phase)
  );

  scan_driver u_scan (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .frame       (frame),
    .scan_tick   (scan_tick),
    .blink_phase (blink_phase),
    .blink       (blink),
    .led_in      (led_in),
    .seg_en      (seg_en),
    .seg         (seg),
    .led_out     (led_out)
  );

endmodule

// File: testbench/display_tb.sv
`timescale 1ns/10ps

module display_tb;
  import display_pkg::*;

  localparam int QUEUE_DEPTH = 2;
  localparam int SCAN_DIV    = 4;
  localparam int BLINK_DIV   = 16;
  localparam int WAIT_LIMIT  = 512;  // Cycles allowed for any single wait

  logic                          clk;
  logic                          rst;
  logic                          value_valid;
  logic signed [VALUE_WIDTH-1:0] value;
  logic                          credit_return;
  logic [LED_WIDTH-1:0]          led_in;
  logic                          blink;
  logic [DIGIT_COUNT-1:0]        seg_en;
  logic [7:0]                    seg;
  logic [LED_WIDTH-1:0]          led_out;

  // Sender bookkeeping
  int credits;
  int sent;
  int returned;
  bit scan_started;

  // Vector columns
  logic [LED_WIDTH-1:0]     led_q [$];
  int                       value_q [$];
  logic                     blink_q [$];
  logic                     hold_q [$];
  digit_t [DIGIT_COUNT-1:0] digits_q [$];

  display_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .SCAN_DIV    (SCAN_DIV),
    .BLINK_DIV   (BLINK_DIV)
  ) uut (
    .clk           (clk),
    .rst           (rst),
    .value_valid   (value_valid),
    .value         (value),
    .credit_return (credit_return),
    .led_in        (led_in),
    .blink         (blink),
    .seg_en        (seg_en),
    .seg           (seg),
    .led_out       (led_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  //////////////////////////////
  // Failure and compare tasks
  //////////////////////////////

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_digit(input int idx, input digit_t got, input digit_t expected);
    if (got !== expected) begin
      $display("FAIL at %0t ns: seg digit %0d got %h expected %h", $time, idx, got, expected);
      abort_run();
    end
  endtask

  task automatic check_led(input logic [LED_WIDTH-1:0] got, input logic [LED_WIDTH-1:0] expected);
    if (got !== expected) begin
      $display("FAIL at %0t ns: led_out got %h expected %h", $time, got, expected);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int expected);
    if (got != expected) begin
      $display("FAIL at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string event_name);
    $display("Timeout at %0t ns: %s never came", $time, event_name);
    abort_run();
  endtask

  //////////////////////////////
  // Scan decoding
  //////////////////////////////

  function automatic bit one_low(input logic [DIGIT_COUNT-1:0] en);
    return $countones(~en) == 1;
  endfunction

  function automatic int low_index(input logic [DIGIT_COUNT-1:0] en);
    for (int b = 0; b < DIGIT_COUNT; b++) begin
      if (!en[b]) return b;
    end
    return -1;
  endfunction

  // Active-low a..g patterns back to a digit code
  function automatic bit decode_segments(input logic [7:0] pattern, output digit_t digit);
    decode_segments = 1'b1;
    case (pattern)
      8'hC0: digit = 4'd0;
      8'hF9: digit = 4'd1;
      8'hA4: digit = 4'd2;
      8'hB0: digit = 4'd3;
      8'h99: digit = 4'd4;
      8'h92: digit = 4'd5;
      8'h82: digit = 4'd6;
      8'hF8: digit = 4'd7;
      8'h80: digit = 4'd8;
      8'h90: digit = 4'd9;
      8'hBF: digit = MINUS_DIGIT;
      default: begin
        digit           = 4'd0;
        decode_segments = 1'b0;
      end
    endcase
  endfunction

  //////////////////////////////
  // Cycle stepping and waits
  //////////////////////////////

  // One clock plus the checks that hold on every cycle
  task automatic step_cycle();
    logic [LED_WIDTH-1:0] led_before;
    logic                 blink_before;
    led_before   = led_in;
    blink_before = blink;
    @(posedge clk);
    #1;
    check_led(led_out, led_before);
    if (credit_return) begin
      credits++;
      returned++;
      if (credits > QUEUE_DEPTH) check_count("credits", credits, QUEUE_DEPTH);
    end
    if (seg_en != '1) scan_started = 1'b1;
    if (scan_started && !blink_before && seg_en == '1) begin
      $display("Display went dark at %0t ns although blink was low", $time);
      abort_run();
    end
  endtask

  task automatic send_value(input int v);
    int waited;
    waited = 0;
    while (credits == 0) begin
      if (waited == WAIT_LIMIT) report_timeout("a credit for the next value");
      step_cycle();
      waited++;
    end
    value_valid = 1'b1;
    value       = VALUE_WIDTH'(v);
    credits--;
    sent++;
    step_cycle();
    value_valid = 1'b0;
  endtask

  task automatic wait_returns();
    int waited;
    waited = 0;
    while (returned < sent) begin
      if (waited == WAIT_LIMIT) report_timeout("credit_return");
      step_cycle();
      waited++;
    end
  endtask

  // Every digit must be seen right after a scan tick
  task automatic check_scan(input digit_t [DIGIT_COUNT-1:0] expected);
    logic [DIGIT_COUNT-1:0] seen;
    logic [DIGIT_COUNT-1:0] prev_en;
    digit_t                 shown;
    int                     idx;
    int                     waited;
    seen   = '0;
    waited = 0;
    step_cycle();  // Frame lands in the driver one cycle after credit_return
    prev_en = seg_en;
    while (seen != '1) begin
      if (waited == WAIT_LIMIT) report_timeout("a full scan of all eight digits");
      step_cycle();
      waited++;
      // Lit digit moving to another lit digit marks a tick
      if (one_low(seg_en) && one_low(prev_en) && seg_en != prev_en) begin
        idx = low_index(seg_en);
        // Scan runs from 7 down to 0 and wraps
        check_count("scan digit", idx,
                    (low_index(prev_en) + DIGIT_COUNT - 1) % DIGIT_COUNT);
        if (!decode_segments(seg, shown)) begin
          $display("Unknown segment pattern %h on digit %0d at %0t ns", seg, idx, $time);
          abort_run();
        end
        check_digit(idx, shown, expected[idx]);
        seen[idx] = 1'b1;
      end
      prev_en = seg_en;
    end
  endtask

  // Blank span of eight ticks and some lit digits within 4 blink halves
  task automatic check_blink_spans();
    int blank_run;
    int longest;
    bit lit;
    blank_run = 0;
    longest   = 0;
    lit       = 1'b0;
    for (int c = 0; c < 4 * BLINK_DIV * SCAN_DIV; c++) begin
      step_cycle();
      if (seg_en == '1) begin
        blank_run++;
        if (blank_run > longest) longest = blank_run;
      end else begin
        blank_run = 0;
        lit       = 1'b1;
      end
    end
    if (longest < 8 * SCAN_DIV) begin
      $display("Blink never blanked the display for eight scan ticks");
      abort_run();
    end
    if (!lit) begin
      $display("No digit was lit while blink was high");
      abort_run();
    end
  endtask

  //////////////////////////////
  // Vector file
  //////////////////////////////

  task automatic load_vectors();
    string                    line;
    int                       fd;
    int                       n;
    int                       v;
    logic [LED_WIDTH-1:0]     led;
    logic                     blk;
    logic                     hold;
    digit_t                   d [DIGIT_COUNT];
    digit_t [DIGIT_COUNT-1:0] row;
    fd = $fopen("testbench/display_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/display_vectors.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %d %b %b %h %h %h %h %h %h %h %h", led, v, blk, hold,
                  d[7], d[6], d[5], d[4], d[3], d[2], d[1], d[0]);
      if (n == 12) begin
        // A value has to fit the 24-bit value port to be sent at all
        if (v < -(1 << (VALUE_WIDTH - 1)) || v >= (1 << VALUE_WIDTH)) begin
          $display("Skipping vector value %0d, it does not fit in %0d bits", v, VALUE_WIDTH);
          continue;
        end
        for (int i = 0; i < DIGIT_COUNT; i++) row[i] = d[i];
        led_q.push_back(led);
        value_q.push_back(v);
        blink_q.push_back(blk);
        hold_q.push_back(hold);
        digits_q.push_back(row);
      end else if (n > 0) begin
        $display("Malformed line in the vector file: %s", line);
        abort_run();
      end
    end
    $fclose(fd);
    if (led_q.size() == 0) begin
      $display("The vector file holds no cases");
      abort_run();
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int i;
    $timeformat(-9, 0, "", 0);
    rst          = 1'b1;
    value_valid  = 1'b0;
    value        = '0;
    led_in       = '0;
    blink        = 1'b0;
    credits      = QUEUE_DEPTH;
    sent         = 0;
    returned     = 0;
    scan_started = 1'b0;
    load_vectors();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    i = 0;
    while (i < led_q.size()) begin
      led_in = led_q[i];
      blink  = blink_q[i];
      if (hold_q[i] && i + 1 < led_q.size()) begin
        send_value(value_q[i]);
        i++;
        led_in = led_q[i];
        blink  = blink_q[i];
        send_value(value_q[i]);  // Back to back, no credit left
        check_count("credits", credits, QUEUE_DEPTH - 2);
      end else begin
        send_value(value_q[i]);
      end
      wait_returns();
      check_count("credits", credits, QUEUE_DEPTH);
      check_scan(digits_q[i]);
      if (blink) check_blink_spans();
      i++;
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: testbench/display_vectors.txt
# led(hex) value(signed decimal) blink hold d7 d6 d5 d4 d3 d2 d1 d0
# Digit codes in hex, f is minus; hold 1 sends the next line back to back
0001 0 0 0 0 0 0 0 0 0 0 0
a5a5 1234567 0 0 0 1 2 3 4 5 6 7
00ff -1 0 0 f 0 0 0 0 0 0 1
ffff -8388608 0 0 f 8 3 8 8 6 0 8
# 24-bit pattern ffffff reads back as -1
8000 16777215 0 0 f 0 0 0 0 0 0 1
7ffe 8388607 0 0 0 8 3 8 8 6 0 7
0f0f -9999999 0 0 f 9 9 9 9 9 9 9
6b6b 7654321 0 0 0 7 6 5 4 3 2 1
1234 42 1 0 0 0 0 0 0 0 4 2
# Pair below, display keeps the second
5a5a 777 0 1 0 0 0 0 0 7 7 7
c3c3 -250 0 0 f 0 0 0 0 2 5 0
0000 90210 0 0 0 0 0 9 0 2 1 0
beef -5 1 0 f 0 0 0 0 0 0 5
1357 3 0 0 0 0 0 0 0 0 0 3

// File: filelist.f
logic/display_pkg.sv
logic/bcd_converter.sv
logic/tick_generator.sv
logic/scan_driver.sv
logic/display_top.sv
testbench/display_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -j 0 --top-module display_tb \
		-Mdir obj_dir -f filelist.f
	./obj_dir/Vdisplay_tb

clean:
	rm -rf obj_dir
